// File: lsu_op_pkg.sv
package lsu_op_pkg;

  //////////////////////////////
  // Access size
  //////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,                  // 8 bit access
    SIZE_HALF = 2'b01,                  // 16 bit access
    SIZE_WORD = 2'b10                   // 32 bit access
  } size_e;

  //////////////////////////////
  // Core side request
  //////////////////////////////

  typedef struct packed {
    logic [31:0] operand_a;             // Base operand
    logic [31:0] operand_b;             // Offset operand, summed with operand_a
    logic [31:0] wdata;                 // Store data, right aligned
    size_e       size;
    logic        sext;                  // Sign extend load result
    logic        we;                    // Store when set
  } lsu_op_t;

  // Per transaction info kept until its response returns
  typedef struct packed {
    size_e       size;
    logic        sext;
    logic        we;
    logic [1:0]  offset;                // Low address bits of the access
    logic        last;                  // Clear only for first part of a split
  } lsu_tag_t;

  //////////////////////////////
  // Writeback side result
  //////////////////////////////

  typedef struct packed {
    logic [31:0] rdata;                 // Aligned and extended load data
    logic        err;                   // Bus error on any part
  } lsu_result_t;

endpackage

// File: lsu_bus_pkg.sv
package lsu_bus_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int BE_W   = DATA_W / 8;    // One enable per byte lane

  //////////////////////////////
  // Request channel
  //////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;            // Byte address, unaligned on first part
    logic              we;              // Write when set
    logic [BE_W-1:0]   be;              // Byte lanes touched
    logic [DATA_W-1:0] wdata;           // Write data already in its lanes
  } bus_req_t;

  //////////////////////////////
  // Response channel
  //////////////////////////////

  // Responses come back in request order, one per request
  typedef struct packed {
    logic [DATA_W-1:0] rdata;           // Full word, realigned by the LSU
    logic              err;             // Access fault
  } bus_rsp_t;

endpackage

// File: lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode (
  input  lsu_op_pkg::lsu_op_t   req_op_i,        // Operation from the core
  input  logic                  second_phase_i,  // Second part of a split is issuing
  output lsu_bus_pkg::bus_req_t bus_req_o,       // Bus request for the current part
  output lsu_op_pkg::lsu_tag_t  tag_o,           // Info for the result stage
  output logic                  split_o          // Access crosses a word boundary
);

  logic [lsu_bus_pkg::ADDR_W-1:0] addr;          // Effective address
  logic [1:0]                     offset;        // Byte offset inside the word
  logic [lsu_bus_pkg::BE_W-1:0]   be;
  logic [lsu_bus_pkg::DATA_W-1:0] wdata_rot;     // Store data in its byte lanes

  //////////////////////////////
  // Address and split
  //////////////////////////////

  assign addr   = req_op_i.operand_a + req_op_i.operand_b;
  assign offset = addr[1:0];

  // Word at any non-zero offset, halfword only at offset 3
  assign split_o = ((req_op_i.size == lsu_op_pkg::SIZE_WORD) && (offset != 2'b00)) ||
                   ((req_op_i.size == lsu_op_pkg::SIZE_HALF) && (offset == 2'b11));

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (req_op_i.size)
      lsu_op_pkg::SIZE_BYTE: begin
        be = 4'b0001 << offset;                  // Never split
      end
      lsu_op_pkg::SIZE_HALF: begin
        if (second_phase_i) begin
          be = 4'b0001;                          // Upper byte spills into next word
        end else begin
          case (offset)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;               // Lower byte only, rest follows
          endcase
        end
      end
      default: begin                             // Word
        if (second_phase_i) begin
          case (offset)
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            2'b11:   be = 4'b0111;
            default: be = 4'b0000;               // Aligned word never gets here
          endcase
        end else begin
          be = 4'b1111 << offset;                // Lanes from offset upward
        end
      end
    endcase
  end

  // Rotate left by the offset, same data serves both parts
  always_comb begin
    case (offset)
      2'b00:   wdata_rot = req_op_i.wdata;
      2'b01:   wdata_rot = {req_op_i.wdata[23:0], req_op_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_op_i.wdata[15:0], req_op_i.wdata[31:16]};
      default: wdata_rot = {req_op_i.wdata[7:0],  req_op_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Second part goes to the next aligned word
  assign bus_req_o.addr  = second_phase_i ? ({addr[31:2], 2'b00} + 32'd4) : addr;
  assign bus_req_o.we    = req_op_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  assign tag_o.size   = req_op_i.size;
  assign tag_o.sext   = req_op_i.sext;
  assign tag_o.we     = req_op_i.we;
  assign tag_o.offset = offset;
  assign tag_o.last   = !(split_o && !second_phase_i); // Clear on first part of a split

endmodule

// File: lsu_execute.sv
`timescale 1ns/1ps

module lsu_execute #(
  parameter int MAX_OUTSTANDING = 2              // Credit pool size
) (
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid_i,                      // Core presents an operation
  output logic req_ready_o,                      // Operation accepted this cycle
  input  logic split_i,                          // Operation needs two parts
  output logic second_phase_o,                   // Second part is the one to issue
  output logic bus_req_valid_o,
  input  logic bus_rsp_valid_i,                  // Each response returns a credit
  output logic tag_push_o                        // Push tag along with the request
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] credit_q;                    // Free credits
  logic [CNT_W-1:0] credit_d;
  logic             second_phase_q;              // First part of split already out
  logic             issue;                       // Bus request this cycle
  logic             first_part;                  // Issuing part is followed by another

  //////////////////////////////
  // Issue and handshake
  //////////////////////////////

  // Only registered credits count, so no path from response to request
  assign issue      = req_valid_i && (credit_q != '0);
  assign first_part = split_i && !second_phase_q;

  assign bus_req_valid_o = issue;
  assign tag_push_o      = issue;                 // Tag travels with every request
  assign req_ready_o     = issue && !first_part;  // Held low during first part
  assign second_phase_o  = second_phase_q;

  //////////////////////////////
  // Split phase tracking
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      second_phase_q <= 1'b0;
    end else begin
      if (!req_valid_i) begin
        second_phase_q <= 1'b0;                   // Nothing pending, start clean
      end else if (issue) begin
        second_phase_q <= first_part;             // Set after first part, clear after last
      end
    end
  end

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  // Spend one per request, regain one per response
  always_comb begin
    case ({issue, bus_rsp_valid_i})
      2'b10: begin
        credit_d = credit_q - 1'b1;
      end
      2'b01: begin
        credit_d = credit_q + 1'b1;
      end
      default: begin
        credit_d = credit_q;                      // None or both cancel out
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= CNT_W'(MAX_OUTSTANDING);        // Full pool after reset
    end else begin
      credit_q <= credit_d;
    end
  end

endmodule

// File: lsu_result.sv
`timescale 1ns/1ps

module lsu_result #(
  parameter int MAX_OUTSTANDING = 2              // Tag FIFO depth
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tag_push_i,       // Request issued this cycle
  input  lsu_op_pkg::lsu_tag_t     tag_i,
  input  logic                     bus_rsp_valid_i,
  input  lsu_bus_pkg::bus_rsp_t    bus_rsp_i,
  output logic                     result_valid_o,   // One cycle per operation
  output lsu_op_pkg::lsu_result_t  result_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  lsu_op_pkg::lsu_tag_t   tag_fifo [MAX_OUTSTANDING];  // In flight tags, oldest at rd_ptr
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  lsu_op_pkg::lsu_tag_t   head;                        // Tag of the responding transaction

  logic [31:0]            lo_data_q;                   // First part of a split load
  logic                   lo_err_q;
  logic                   is_split;
  logic [63:0]            rdata_full;
  logic [31:0]            rdata_aligned;               // Access bytes moved down to lane 0
  logic [31:0]            rdata_ext;

  //////////////////////////////
  // Tag FIFO
  //////////////////////////////

  // Credits bound the fill level, no full or empty checks needed
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (tag_push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (bus_rsp_valid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_push_i) tag_fifo[wr_ptr_q] <= tag_i;
  end

  assign head = tag_fifo[rd_ptr_q];

  //////////////////////////////
  // Realign and extend
  //////////////////////////////

  assign is_split = ((head.size == lsu_op_pkg::SIZE_WORD) && (head.offset != 2'b00)) ||
                    ((head.size == lsu_op_pkg::SIZE_HALF) && (head.offset == 2'b11));

  // Saved low word below the new one, or the word twice for in-word shifts
  assign rdata_full    = is_split ? {bus_rsp_i.rdata, lo_data_q} :
                                    {bus_rsp_i.rdata, bus_rsp_i.rdata};
  assign rdata_aligned = rdata_full[{head.offset, 3'b000} +: 32];

  always_comb begin
    case (head.size)
      lsu_op_pkg::SIZE_BYTE: rdata_ext = {{24{head.sext && rdata_aligned[7]}},  rdata_aligned[7:0]};
      lsu_op_pkg::SIZE_HALF: rdata_ext = {{16{head.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:               rdata_ext = rdata_aligned[31:0];
    endcase
  end

  //////////////////////////////
  // First part and result regs
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (bus_rsp_valid_i && !head.last) begin
      if (!head.we) lo_data_q <= bus_rsp_i.rdata;        // Store data is never read back
      lo_err_q <= bus_rsp_i.err;
    end
    if (bus_rsp_valid_i && head.last) begin
      result_o.rdata <= rdata_ext;
      result_o.err   <= bus_rsp_i.err || (is_split && lo_err_q); // Either part faults
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= bus_rsp_valid_i && head.last;    // Only last part reports
    end
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int MAX_OUTSTANDING = 2              // Outstanding bus transactions
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // Core side
  input  logic                     req_valid_i,
  input  lsu_op_pkg::lsu_op_t      req_op_i,
  output logic                     req_ready_o,
  // Data bus, credit based
  output logic                     bus_req_valid_o,
  output lsu_bus_pkg::bus_req_t    bus_req_o,
  input  logic                     bus_rsp_valid_i,
  input  lsu_bus_pkg::bus_rsp_t    bus_rsp_i,
  // Writeback
  output logic                     result_valid_o,
  output lsu_op_pkg::lsu_result_t  result_o
);

  logic                  second_phase;           // Execute to decode
  logic                  split;                  // Decode to execute
  lsu_op_pkg::lsu_tag_t  tag;                    // Decode to result FIFO
  logic                  tag_push;

  //////////////////////////////
  // Pipeline blocks
  //////////////////////////////

  lsu_decode i_decode (
    .req_op_i       ( req_op_i     ),
    .second_phase_i ( second_phase ),
    .bus_req_o      ( bus_req_o    ),            // Straight onto the bus
    .tag_o          ( tag          ),
    .split_o        ( split        )
  );

  lsu_execute #(
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  ) i_execute (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .split_i         ( split           ),
    .second_phase_o  ( second_phase    ),
    .bus_req_valid_o ( bus_req_valid_o ),
    .bus_rsp_valid_i ( bus_rsp_valid_i ),
    .tag_push_o      ( tag_push        )
  );

  lsu_result #(
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  ) i_result (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .tag_push_i      ( tag_push        ),
    .tag_i           ( tag             ),
    .bus_rsp_valid_i ( bus_rsp_valid_i ),
    .bus_rsp_i       ( bus_rsp_i       ),
    .result_valid_o  ( result_valid_o  ),
    .result_o        ( result_o        )
  );

endmodule

// File: lsu_props.sv
`timescale 1ns/1ps

module lsu_props #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bus_req_valid_i,
  input  lsu_bus_pkg::bus_req_t bus_req_i,
  input  logic                  bus_rsp_valid_i,
  input  logic                  second_phase_i   // Execute is on the second part
);

  int unsigned outstanding_q;                     // Requests without a response
  logic [31:0] first_addr_q;                      // Address of the last first part
  int unsigned n_fail = 0;                        // Property failures so far

  //////////////////////////////
  // Shadow state
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 0;
      first_addr_q  <= '0;
    end else begin
      outstanding_q <= outstanding_q + (bus_req_valid_i ? 1 : 0) - (bus_rsp_valid_i ? 1 : 0);
      if (bus_req_valid_i && !second_phase_i) first_addr_q <= bus_req_i.addr;
    end
  end

  //////////////////////////////
  // Properties
  //////////////////////////////

  a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= MAX_OUTSTANDING)
    else begin
      n_fail++;
      $error("More bus transactions in flight than credits");
    end

  a_idle_in_reset : assert property (@(posedge clk)
    !rst_n |-> !bus_req_valid_i)
    else begin
      n_fail++;
      $error("Bus request raised during reset");
    end

  a_be_nonzero : assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_i |-> (bus_req_i.be != '0))
    else begin
      n_fail++;
      $error("Bus request with no byte enabled");
    end

  // Second part lands on the word after the first part
  a_split_addr : assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_valid_i && second_phase_i) |->
      (bus_req_i.addr == ({first_addr_q[31:2], 2'b00} + 32'd4)))
    else begin
      n_fail++;
      $error("Second part of a split not at the next aligned word");
    end

endmodule

bind lsu_top lsu_props #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_props (
  .clk             ( clk             ),
  .rst_n           ( rst_n           ),
  .bus_req_valid_i ( bus_req_valid_o ),
  .bus_req_i       ( bus_req_o       ),
  .bus_rsp_valid_i ( bus_rsp_valid_i ),
  .second_phase_i  ( second_phase    )
);

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,                   // 20 ns period
  output logic rst_n_o                  // Low for the first 10 cycles
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;                    // Release on an edge like other inputs
  end

  always #10 clk_o = ~clk_o;

endmodule

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  localparam int MAX_OUTSTANDING = 2;
  localparam int N_OPS           = 70;                    // Operations issued below
  localparam int TIMEOUT         = 40 * N_OPS + 10;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        we;                                      // Store, rdata not compared
  } exp_res_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
  } exp_req_t;

  typedef struct packed {
    int          due;                                     // Cycle the response goes out
    logic [31:0] rdata;
    logic        err;
  } pend_rsp_t;

  logic clk;
  logic rst_n;
  logic                     req_valid_i;
  lsu_op_pkg::lsu_op_t      req_op_i;
  logic                     req_ready_o;
  logic                     bus_req_valid_o;
  lsu_bus_pkg::bus_req_t    bus_req_o;
  logic                     bus_rsp_valid_i;
  lsu_bus_pkg::bus_rsp_t    bus_rsp_i;
  logic                     result_valid_o;
  lsu_op_pkg::lsu_result_t  result_o;

  logic [31:0] mem     [64];                              // Bus side memory
  logic [31:0] ref_mem [64];                              // Program order image
  exp_res_t    exp_q[$];
  exp_req_t    req_q[$];
  pend_rsp_t   rsp_q[$];
  int          cycle = 0;
  int          errors = 0;
  int          n_results = 0;
  int          n_reqs = 0;
  int          last_due = 0;
  logic [31:0] rng_lat = 32'h3a3e_53ce;
  logic [31:0] rng_stim = 32'h3a3e_53ce;
  logic        started = 1'b0;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_lsu_top (
    .clk(clk), .rst_n(rst_n), .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_ready_o(req_ready_o), .bus_req_valid_o(bus_req_valid_o), .bus_req_o(bus_req_o),
    .bus_rsp_valid_i(bus_rsp_valid_i), .bus_rsp_i(bus_rsp_i),
    .result_valid_o(result_valid_o), .result_o(result_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////
  // Memory model
  //////////////////////////////

  always @(posedge clk) begin : memory_model
    exp_req_t    er;
    pend_rsp_t   pr;
    logic [5:0]  idx;
    int          due;
    if (!rst_n) begin
      bus_rsp_valid_i <= 1'b0;
    end else begin
      if (rsp_q.size() > 0 && rsp_q[0].due <= cycle) begin   // Oldest first
        pr = rsp_q.pop_front();
        bus_rsp_valid_i <= 1'b1;
        bus_rsp_i       <= '{rdata: pr.rdata, err: pr.err};
      end else begin
        bus_rsp_valid_i <= 1'b0;
      end
      if (bus_req_valid_o) begin
        n_reqs++;
        if (req_q.size() == 0) begin
          errors++;
          $display("Bus request seen with no request expected");
        end else begin
          er = req_q.pop_front();
          assert (bus_req_o.addr == er.addr) else begin
            errors++;
            $display("FAILED bus_req_o.addr: got %h expected %h", bus_req_o.addr, er.addr);
          end
          assert (bus_req_o.be == er.be) else begin
            errors++;
            $display("FAILED bus_req_o.be: got %h expected %h", bus_req_o.be, er.be);
          end
        end
        idx = bus_req_o.addr[7:2];
        if (bus_req_o.we && idx != 6'd63) begin
          for (int k = 0; k < 4; k++) begin
            if (bus_req_o.be[k]) mem[idx][8*k +: 8] = bus_req_o.wdata[8*k +: 8];
          end
        end
        rng_lat = lcg_next(rng_lat);
        due     = cycle + 1 + int'(rng_lat[17:16]);      // 1 to 4 cycles
        if (due <= last_due) due = last_due + 1;          // Keep order, one per cycle
        last_due = due;
        rsp_q.push_back('{due: due, rdata: mem[idx], err: (idx == 6'd63)});
      end
    end
  end

  //////////////////////////////
  // Checkers
  //////////////////////////////

  always @(negedge clk) begin : check_results
    exp_res_t e;
    if (rst_n && result_valid_o) begin
      n_results++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Result seen with no operation outstanding");
      end else begin
        e = exp_q.pop_front();
        if (!e.we) begin
          assert (result_o.rdata == e.rdata) else begin
            errors++;
            $display("FAILED result_o.rdata: got %h expected %h", result_o.rdata, e.rdata);
          end
        end
        assert (result_o.err == e.err) else begin
          errors++;
          $display("FAILED result_o.err: got %h expected %h", result_o.err, e.err);
        end
      end
    end
    if (!started) begin                                   // Quiet until first request
      if (req_valid_i) started = 1'b1;
      else assert (!bus_req_valid_o && !result_valid_o) else begin
        errors++;
        $display("Bus request or result raised before any request");
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d results still expected", cycle, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Expected values from byte-wise model of the reference image
  task automatic do_op(input logic [31:0] a, input logic [31:0] b, input logic [31:0] wd,
                       input lsu_op_pkg::size_e sz, input logic sx, input logic we);
    logic [31:0] addr;
    logic [31:0] ba;
    logic [31:0] rdata;
    logic        err;
    logic [3:0]  be0;
    logic [3:0]  be1;
    int          n;
    addr  = a + b;
    n     = (sz == lsu_op_pkg::SIZE_BYTE) ? 1 : (sz == lsu_op_pkg::SIZE_HALF) ? 2 : 4;
    rdata = '0;
    err   = 1'b0;
    be0   = '0;
    be1   = '0;
    for (int k = 0; k < n; k++) begin
      ba = addr + k;
      if (ba[7:2] == 6'd63) err = 1'b1;
      if (ba[7:2] == addr[7:2]) be0[ba[1:0]] = 1'b1;
      else be1[ba[1:0]] = 1'b1;
      if (we) begin
        if (ba[7:2] != 6'd63) ref_mem[ba[7:2]][{ba[1:0], 3'b000} +: 8] = wd[8*k +: 8];
      end else begin
        rdata[8*k +: 8] = ref_mem[ba[7:2]][{ba[1:0], 3'b000} +: 8];
      end
    end
    if (sx && n == 1) rdata[31:8]  = {24{rdata[7]}};
    if (sx && n == 2) rdata[31:16] = {16{rdata[15]}};
    req_q.push_back('{addr: addr, be: be0});
    if (be1 != '0) req_q.push_back('{addr: {addr[31:2], 2'b00} + 32'd4, be: be1});
    exp_q.push_back('{rdata: rdata, err: err, we: we});
    req_valid_i <= 1'b1;
    req_op_i    <= '{operand_a: a, operand_b: b, wdata: wd, size: sz, sext: sx, we: we};
    do @(negedge clk); while (!req_ready_o);
    @(posedge clk);                                       // Handshake edge
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] b;
    req_valid_i     = 1'b0;
    req_op_i        = '0;
    bus_rsp_valid_i = 1'b0;
    bus_rsp_i       = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = 32'hc3a5_0000 ^ (i * 32'h0103_0907) ^ {26'd0, i[5:0]};
      ref_mem[i] = mem[i];
    end
    @(posedge rst_n);
    repeat (2) @(posedge clk);                            // Idle check window

    do_op(32'h40, 32'h0, 32'hdead_beef, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b1);
    do_op(32'h3c, 32'h4, 32'h0, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b0);
    // Byte and halfword loads at every offset
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        do_op(32'h80, off, 32'h0, lsu_op_pkg::SIZE_BYTE, s[0], 1'b0);
        do_op(32'h90, off, 32'h0, lsu_op_pkg::SIZE_HALF, s[0], 1'b0);
      end
    end
    // Split stores and loads
    for (int off = 1; off < 4; off++) begin
      do_op(32'h20 + 8 * off, off, 32'h1234_5678 + off, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b1);
      do_op(32'h20 + 8 * off, off, 32'h0, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b0);
    end
    do_op(32'hb0, 32'h3, 32'h0000_a55a, lsu_op_pkg::SIZE_HALF, 1'b0, 1'b1);
    do_op(32'hb0, 32'h3, 32'h0, lsu_op_pkg::SIZE_HALF, 1'b1, 1'b0);
    // Error word, direct and through either split part
    do_op(32'hfc, 32'h0, 32'h0, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b0);
    do_op(32'hf8, 32'h2, 32'h0, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b0);
    do_op(32'hf8, 32'h3, 32'h0, lsu_op_pkg::SIZE_HALF, 1'b1, 1'b0);
    do_op(32'hfc, 32'h2, 32'h0, lsu_op_pkg::SIZE_WORD, 1'b0, 1'b0);   // First part faults
    // Random back-to-back traffic
    for (int i = 0; i < 40; i++) begin
      rng_stim = lcg_next(rng_stim);
      addr     = 32'(rng_stim[15:8] % 8'd244);            // Second part stays below word 62
      b        = {28'd0, rng_stim[3:0]};
      do_op(addr - b, b, lcg_next(rng_stim),
            lsu_op_pkg::size_e'(rng_stim[17:16] % 2'd3), rng_stim[18], rng_stim[19]);
    end
    req_valid_i <= 1'b0;

    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    for (int i = 0; i < 64; i++) begin
      assert (mem[i] == ref_mem[i]) else begin
        errors++;
        $display("FAILED mem[%0d]: got %h expected %h", i, mem[i], ref_mem[i]);
      end
    end
    if (req_q.size() != 0) begin
      errors++;
      $display("Expected bus requests were never issued");
    end
    errors += int'(i_lsu_top.i_props.n_fail);             // Concurrent property failures
    $display("Results checked: %0d, bus requests checked: %0d, errors: %0d",
             n_results, n_reqs, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: filelist.f
lsu_op_pkg.sv
lsu_bus_pkg.sv
lsu_decode.sv
lsu_execute.sv
lsu_result.sv
lsu_top.sv
lsu_props.sv
tb_clk_gen.sv
tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
